// File: cp0_params.svh
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// TLB geometry, 4 KB pages only
`define TLB_ENTRIES     16
`define TLB_IDX_BITS    4

// Reset values
`define INIT_STATUS     32'h0040_0000          // BEV set, ERL, EXL and IE clear
`define INIT_PRID       32'h0001_8003
`define INIT_RANDOM     (32'(`TLB_ENTRIES - 1))

// Software-writable fields per register
`define WMASK_INDEX     ((32'd1 << `TLB_IDX_BITS) - 32'd1)
`define WMASK_WIRED     ((32'd1 << `TLB_IDX_BITS) - 32'd1)
`define WMASK_ENTRYLO   32'h03ff_ffff          // PFN, C, D, V, G
`define WMASK_ENTRYHI   32'hffff_e0ff          // VPN2 and ASID
`define WMASK_STATUS    32'h1040_ff13          // CU0, BEV, IM, UM, EXL, IE
`define WMASK_CAUSE     32'h0080_0300          // IV and software IP

`endif

// File: cp0_pkg.sv
package cp0_pkg;

    // Register numbers, select field is always 0
    typedef enum logic [4:0] {
        CP0_INDEX    = 5'd0,
        CP0_RANDOM   = 5'd1,
        CP0_ENTRYLO0 = 5'd2,
        CP0_ENTRYLO1 = 5'd3,
        CP0_WIRED    = 5'd6,
        CP0_BADVADDR = 5'd8,
        CP0_COUNT    = 5'd9,
        CP0_ENTRYHI  = 5'd10,
        CP0_COMPARE  = 5'd11,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14,
        CP0_PRID     = 5'd15
    } cp0_reg_e;

    // Cause.ExcCode
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

endpackage

// File: tlb_pkg.sv
package tlb_pkg;

    // Segment encodings of va[31:29]
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;   // Even page
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;   // Odd page
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] off;
    } va_seg_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] offset;
    } va_page_t;

    // Same 32-bit address seen by segment or by page
    typedef union packed {
        va_seg_t  seg_v;
        va_page_t page_v;
    } vaddr_u;

endpackage

// File: addr_translate.sv
`timescale 1ns/1ps

module addr_translate
    import tlb_pkg::*;
(
    input  logic [31:0] va_i,
    input  logic        write_i,
    input  logic        hit_i,
    input  logic [19:0] pfn_i,
    input  logic [2:0]  c_i,
    input  logic        d_i,
    input  logic        v_i,
    output logic [31:0] pa_o,
    output logic        uncached_o,
    output logic        miss_o,
    output logic        invalid_o,
    output logic        modified_o
);

    vaddr_u va;
    logic   unmapped;

    assign va = va_i;

    // kseg0 and kseg1 bypass the TLB
    assign unmapped = (va.seg_v.seg == SEG_KSEG0) || (va.seg_v.seg == SEG_KSEG1);

    always_comb begin
        if (unmapped) begin
            pa_o       = {3'b000, va.seg_v.off};
            uncached_o = (va.seg_v.seg == SEG_KSEG1);
        end else begin
            pa_o       = {pfn_i, va.page_v.offset};
            uncached_o = (c_i == 3'd2);
        end
    end

    assign miss_o     = !unmapped && !hit_i;
    assign invalid_o  = !unmapped && hit_i && !v_i;
    assign modified_o = !unmapped && hit_i && v_i && write_i && !d_i;   // Store to clean page

    always_comb begin
        if (unmapped)
            a_unmapped_quiet: assert final (!(miss_o || invalid_o || modified_o));
    end

endmodule

// File: tlb_array.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module tlb_array
    import tlb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we_i,
    input  logic [`TLB_IDX_BITS-1:0] index_i,
    input  tlb_entry_t               wr_entry_i,
    input  logic [`TLB_IDX_BITS-1:0] rd_index_i,
    input  logic [7:0]               asid_i,
    input  logic [18:0]              probe_vpn2_i,
    input  logic [31:0]              lookup_va0_i,
    input  logic [31:0]              lookup_va1_i,
    output tlb_entry_t               rd_entry_o,
    output logic                     probe_hit_o,
    output logic [`TLB_IDX_BITS-1:0] probe_index_o,
    output logic                     hit0_o,
    output logic [19:0]              pfn0_o,
    output logic [2:0]               c0_o,
    output logic                     d0_o,
    output logic                     v0_o,
    output logic                     hit1_o,
    output logic [19:0]              pfn1_o,
    output logic [2:0]               c1_o,
    output logic                     d1_o,
    output logic                     v1_o
);

    tlb_entry_t               entry_q [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0]  filled_q;   // Entry has been written since reset
    logic [`TLB_ENTRIES-1:0]  probe_m, m0, m1;
    tlb_entry_t               sel0, sel1;
    vaddr_u                   va0, va1;

    function automatic logic [`TLB_ENTRIES-1:0] match_vec(input logic [18:0] vpn2);
        logic [`TLB_ENTRIES-1:0] m;
        for (int i = 0; i < `TLB_ENTRIES; i++)
            m[i] = filled_q[i] && entry_q[i].vpn2 == vpn2 &&
                   (entry_q[i].g || entry_q[i].asid == asid_i);
        return m;
    endfunction

    // {pfn, c, d, v} of the page picked by the odd bit
    function automatic logic [24:0] page_half(input tlb_entry_t e, input logic odd);
        return odd ? {e.pfn1, e.c1, e.d1, e.v1} : {e.pfn0, e.c0, e.d0, e.v0};
    endfunction

    always_ff @(posedge clk) begin
        if (we_i)
            entry_q[index_i] <= wr_entry_i;
    end

    always_ff @(posedge clk) begin
        if (rst)
            filled_q <= '0;
        else if (we_i)
            filled_q[index_i] <= 1'b1;
    end

    assign va0 = lookup_va0_i;
    assign va1 = lookup_va1_i;

    always_comb begin
        probe_m       = match_vec(probe_vpn2_i);
        m0            = match_vec(va0.page_v.vpn2);
        m1            = match_vec(va1.page_v.vpn2);
        probe_index_o = '0;
        sel0          = '0;
        sel1          = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (probe_m[i])
                probe_index_o = i[`TLB_IDX_BITS-1:0];
            if (m0[i])
                sel0 = entry_q[i];
            if (m1[i])
                sel1 = entry_q[i];
        end
    end

    assign rd_entry_o  = entry_q[rd_index_i];
    assign probe_hit_o = |probe_m;
    assign hit0_o      = |m0;
    assign hit1_o      = |m1;
    assign {pfn0_o, c0_o, d0_o, v0_o} = page_half(sel0, va0.page_v.odd);
    assign {pfn1_o, c1_o, d1_o, v1_o} = page_half(sel1, va1.page_v.odd);

    a_single_match: assert property (@(posedge clk) disable iff (rst)
        $onehot0(m0) && $onehot0(m1));

endmodule

// File: cp0_regs.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_regs
    import cp0_pkg::*, tlb_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4:0]               rd_addr_i,
    input  logic [4:0]               wr_addr_i,
    input  logic                     we_i,
    input  logic [31:0]              wdata_i,
    input  logic                     tlbwi_i,
    input  logic                     tlbwr_i,
    input  logic                     tlbr_i,
    input  logic                     tlbp_i,
    input  logic                     exc_i,
    input  logic                     exc_bd_i,
    input  exc_code_e                exc_code_i,
    input  logic [31:0]              exc_epc_i,
    input  logic [31:0]              exc_badvaddr_i,
    input  logic                     exc_badvaddr_we_i,
    input  logic                     eret_i,
    input  logic [5:0]               hw_int_i,
    input  tlb_entry_t               tlb_rd_entry_i,
    input  logic                     probe_hit_i,
    input  logic [`TLB_IDX_BITS-1:0] probe_index_i,
    output logic [31:0]              rdata_o,
    output logic                     tlb_we_o,
    output logic [`TLB_IDX_BITS-1:0] tlb_index_o,
    output tlb_entry_t               tlb_wr_entry_o,
    output logic [7:0]               asid_o,
    output logic [7:0]               interrupt_flag_o,
    output logic                     allow_int_o,
    output logic [31:0]              epc_o
);

    logic [31:0] index_q, random_q, entrylo0_q, entrylo1_q, wired_q;
    logic [31:0] badvaddr_q, count_q, compare_q, entryhi_q;
    logic [31:0] status_q, cause_q, epc_q;
    logic        count_tick;
    logic [`TLB_IDX_BITS-1:0] random_nxt;

    function automatic logic [31:0] wmerge(input logic [31:0] old_v,
                                           input logic [31:0] new_v,
                                           input logic [31:0] mask);
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    always_comb begin
        case (rd_addr_i)
            CP0_INDEX:    rdata_o = index_q;
            CP0_RANDOM:   rdata_o = random_q;
            CP0_ENTRYLO0: rdata_o = entrylo0_q;
            CP0_ENTRYLO1: rdata_o = entrylo1_q;
            CP0_WIRED:    rdata_o = wired_q;
            CP0_BADVADDR: rdata_o = badvaddr_q;
            CP0_COUNT:    rdata_o = count_q;
            CP0_ENTRYHI:  rdata_o = entryhi_q;
            CP0_COMPARE:  rdata_o = compare_q;
            CP0_STATUS:   rdata_o = status_q;
            CP0_CAUSE:    rdata_o = cause_q;
            CP0_EPC:      rdata_o = epc_q;
            CP0_PRID:     rdata_o = `INIT_PRID;
            default:      rdata_o = 32'd0;
        endcase
    end

    // Next Random after tlbwr, never below Wired
    always_comb begin
        random_nxt = random_q[`TLB_IDX_BITS-1:0] + 1'b1;
        if (random_nxt < wired_q[`TLB_IDX_BITS-1:0])
            random_nxt = wired_q[`TLB_IDX_BITS-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index_q    <= 32'd0;
            random_q   <= `INIT_RANDOM;
            entrylo0_q <= 32'd0;
            entrylo1_q <= 32'd0;
            wired_q    <= 32'd0;
            badvaddr_q <= 32'd0;
            count_q    <= 32'd0;
            compare_q  <= 32'd0;
            entryhi_q  <= 32'd0;
            status_q   <= `INIT_STATUS;
            cause_q    <= 32'd0;
            epc_q      <= 32'd0;
            count_tick <= 1'b0;
        end else begin
            count_tick     <= ~count_tick;
            count_q        <= count_q + {31'd0, count_tick};
            cause_q[15:10] <= hw_int_i;              // Sampled hardware IP
            if (count_q == compare_q)
                cause_q[30] <= 1'b1;                 // Timer pending, sticky
            if (we_i) begin
                case (wr_addr_i)
                    CP0_INDEX:    index_q    <= wmerge(index_q, wdata_i, `WMASK_INDEX);
                    CP0_ENTRYLO0: entrylo0_q <= wmerge(entrylo0_q, wdata_i, `WMASK_ENTRYLO);
                    CP0_ENTRYLO1: entrylo1_q <= wmerge(entrylo1_q, wdata_i, `WMASK_ENTRYLO);
                    CP0_WIRED: begin
                        wired_q  <= wmerge(wired_q, wdata_i, `WMASK_WIRED);
                        random_q <= `INIT_RANDOM;
                    end
                    CP0_COUNT:    count_q    <= wdata_i;
                    CP0_ENTRYHI:  entryhi_q  <= wmerge(entryhi_q, wdata_i, `WMASK_ENTRYHI);
                    CP0_COMPARE: begin
                        compare_q   <= wdata_i;
                        cause_q[30] <= 1'b0;         // Acknowledge timer
                    end
                    CP0_STATUS:   status_q   <= wmerge(status_q, wdata_i, `WMASK_STATUS);
                    CP0_CAUSE: begin
                        cause_q[23]  <= wdata_i[23];
                        cause_q[9:8] <= wdata_i[9:8];
                    end
                    CP0_EPC:      epc_q      <= wdata_i;
                    default: ;
                endcase
            end else begin
                if (tlbr_i) begin
                    entryhi_q  <= {tlb_rd_entry_i.vpn2, 5'd0, tlb_rd_entry_i.asid};
                    entrylo0_q <= {6'd0, tlb_rd_entry_i.pfn0, tlb_rd_entry_i.c0,
                                   tlb_rd_entry_i.d0, tlb_rd_entry_i.v0, tlb_rd_entry_i.g};
                    entrylo1_q <= {6'd0, tlb_rd_entry_i.pfn1, tlb_rd_entry_i.c1,
                                   tlb_rd_entry_i.d1, tlb_rd_entry_i.v1, tlb_rd_entry_i.g};
                end
                if (tlbp_i)
                    index_q <= {~probe_hit_i, {(31 - `TLB_IDX_BITS){1'b0}}, probe_index_i};
                if (tlbwr_i)
                    random_q <= {{(32 - `TLB_IDX_BITS){1'b0}}, random_nxt};
                if (exc_i) begin
                    if (exc_badvaddr_we_i) begin
                        badvaddr_q       <= exc_badvaddr_i;
                        entryhi_q[31:13] <= exc_badvaddr_i[31:13];
                    end
                    cause_q[31]  <= exc_bd_i;
                    cause_q[6:2] <= exc_code_i;
                    epc_q        <= exc_epc_i;
                    status_q[1]  <= 1'b1;            // EXL
                end
                if (eret_i)
                    status_q[1] <= 1'b0;
            end
        end
    end

    assign tlb_we_o    = tlbwi_i | tlbwr_i;
    assign tlb_index_o = tlbwr_i ? random_q[`TLB_IDX_BITS-1:0] : index_q[`TLB_IDX_BITS-1:0];
    assign asid_o      = entryhi_q[7:0];

    // G is stored once, the AND of both halves
    assign tlb_wr_entry_o = '{
        vpn2: entryhi_q[31:13],
        asid: entryhi_q[7:0],
        g:    entrylo0_q[0] & entrylo1_q[0],
        pfn0: entrylo0_q[25:6], c0: entrylo0_q[5:3], d0: entrylo0_q[2], v0: entrylo0_q[1],
        pfn1: entrylo1_q[25:6], c1: entrylo1_q[5:3], d1: entrylo1_q[2], v1: entrylo1_q[1]
    };

    assign interrupt_flag_o = status_q[15:8] & {hw_int_i, cause_q[9:8]};
    assign allow_int_o      = (status_q[2:0] == 3'b001) && !exc_i;
    assign epc_o            = epc_q;

    a_one_tlb_op: assert property (@(posedge clk) disable iff (rst)
        $onehot0({tlbwi_i, tlbwr_i, tlbr_i, tlbp_i}));

    // Holds across tlbwr sequences and Wired writes
    a_random_above_wired: assert property (@(posedge clk) disable iff (rst)
        random_q[`TLB_IDX_BITS-1:0] >= wired_q[`TLB_IDX_BITS-1:0]);

endmodule

// File: cp0_mmu_top.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_mmu_top
    import cp0_pkg::*, tlb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rd_addr_i,
    input  logic [4:0]  wr_addr_i,
    input  logic        we_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    input  logic        tlbwi_i,
    input  logic        tlbwr_i,
    input  logic        tlbr_i,
    input  logic        tlbp_i,
    input  logic        exc_i,
    input  logic        exc_bd_i,
    input  exc_code_e   exc_code_i,
    input  logic [31:0] exc_epc_i,
    input  logic [31:0] exc_badvaddr_i,
    input  logic        exc_badvaddr_we_i,
    input  logic        eret_i,
    input  logic [5:0]  hw_int_i,
    output logic [7:0]  interrupt_flag_o,
    output logic        allow_int_o,
    output logic [31:0] epc_o,
    input  logic [31:0] iaddr_i,
    output logic [31:0] ipaddr_o,
    output logic        iuncached_o,
    output logic        imiss_o,
    output logic        iinvalid_o,
    input  logic [31:0] daddr_i,
    input  logic        dwrite_i,
    output logic [31:0] dpaddr_o,
    output logic        duncached_o,
    output logic        dmiss_o,
    output logic        dinvalid_o,
    output logic        dmodified_o
);

    logic                     tlb_we, probe_hit;
    logic [`TLB_IDX_BITS-1:0] tlb_index, probe_index;
    tlb_entry_t               tlb_wr_entry, tlb_rd_entry;
    logic [7:0]               asid;
    logic                     ihit, id, iv, dhit, dd, dv;
    logic [19:0]              ipfn, dpfn;
    logic [2:0]               ic, dc;

    cp0_regs u_regs (
        .clk, .rst, .rd_addr_i, .wr_addr_i, .we_i, .wdata_i,
        .tlbwi_i, .tlbwr_i, .tlbr_i, .tlbp_i,
        .exc_i, .exc_bd_i, .exc_code_i, .exc_epc_i, .exc_badvaddr_i, .exc_badvaddr_we_i,
        .eret_i, .hw_int_i,
        .tlb_rd_entry_i (tlb_rd_entry),
        .probe_hit_i    (probe_hit),
        .probe_index_i  (probe_index),
        .rdata_o, .tlb_we_o(tlb_we), .tlb_index_o(tlb_index),
        .tlb_wr_entry_o (tlb_wr_entry),
        .asid_o         (asid),
        .interrupt_flag_o, .allow_int_o, .epc_o
    );

    // tlbr reads at Index, which tlb_index carries when tlbwr is low
    tlb_array u_tlb (
        .clk, .rst,
        .we_i (tlb_we), .index_i(tlb_index), .wr_entry_i(tlb_wr_entry),
        .rd_index_i (tlb_index), .asid_i(asid), .probe_vpn2_i(tlb_wr_entry.vpn2),
        .lookup_va0_i (iaddr_i), .lookup_va1_i(daddr_i),
        .rd_entry_o (tlb_rd_entry), .probe_hit_o(probe_hit), .probe_index_o(probe_index),
        .hit0_o(ihit), .pfn0_o(ipfn), .c0_o(ic), .d0_o(id), .v0_o(iv),
        .hit1_o(dhit), .pfn1_o(dpfn), .c1_o(dc), .d1_o(dd), .v1_o(dv)
    );

    addr_translate u_itrans (
        .va_i(iaddr_i), .write_i(1'b0),
        .hit_i(ihit), .pfn_i(ipfn), .c_i(ic), .d_i(id), .v_i(iv),
        .pa_o(ipaddr_o), .uncached_o(iuncached_o), .miss_o(imiss_o),
        .invalid_o(iinvalid_o), .modified_o()
    );

    addr_translate u_dtrans (
        .va_i(daddr_i), .write_i(dwrite_i),
        .hit_i(dhit), .pfn_i(dpfn), .c_i(dc), .d_i(dd), .v_i(dv),
        .pa_o(dpaddr_o), .uncached_o(duncached_o), .miss_o(dmiss_o),
        .invalid_o(dinvalid_o), .modified_o(dmodified_o)
    );

endmodule

// File: tb_cp0_mmu.sv
`timescale 1ns/1ps
`include "cp0_params.svh"

module tb_cp0_mmu
    import cp0_pkg::*, tlb_pkg::*;
();

    localparam int CYCLE_LIMIT = 4000;   // Stimulus runs about 900 cycles
    localparam int OP_WI = 0, OP_WR = 1, OP_R = 2, OP_P = 3;
    localparam logic [4:0] REG_LIST [13] = '{CP0_INDEX, CP0_RANDOM, CP0_ENTRYLO0,
        CP0_ENTRYLO1, CP0_WIRED, CP0_BADVADDR, CP0_COUNT, CP0_ENTRYHI, CP0_COMPARE,
        CP0_STATUS, CP0_CAUSE, CP0_EPC, CP0_PRID};

    logic clk = 1'b0;
    logic rst;
    logic [4:0] rd_addr_i, wr_addr_i;
    logic we_i, tlbwi_i, tlbwr_i, tlbr_i, tlbp_i;
    logic exc_i, exc_bd_i, exc_badvaddr_we_i, eret_i, dwrite_i;
    logic [31:0] wdata_i, exc_epc_i, exc_badvaddr_i, iaddr_i, daddr_i;
    exc_code_e exc_code_i;
    logic [5:0] hw_int_i;
    logic [31:0] rdata_o, epc_o, ipaddr_o, dpaddr_o;
    logic [7:0] interrupt_flag_o;
    logic allow_int_o, iuncached_o, imiss_o, iinvalid_o;
    logic duncached_o, dmiss_o, dinvalid_o, dmodified_o;

    // Shadow state
    logic [31:0] s_reg [32];
    tlb_entry_t s_tlb [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] s_filled;
    logic s_tick;
    logic [31:0] exp_rdata;
    logic [35:0] exp_i, exp_d;   // {pa, uncached, miss, invalid, modified}

    logic [31:0] rng = 32'hbca4;
    logic [18:0] slot_vpn2 [`TLB_ENTRIES];
    int errors = 0;
    int checked = 0;
    int cycles = 0;
    int rd_pos = 0;

    cp0_mmu_top UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] write_mask(input logic [4:0] a);
        case (a)
            CP0_INDEX:                  return `WMASK_INDEX;
            CP0_WIRED:                  return `WMASK_WIRED;
            CP0_ENTRYLO0, CP0_ENTRYLO1: return `WMASK_ENTRYLO;
            CP0_ENTRYHI:                return `WMASK_ENTRYHI;
            CP0_STATUS:                 return `WMASK_STATUS;
            CP0_CAUSE:                  return `WMASK_CAUSE;
            CP0_COUNT, CP0_COMPARE, CP0_EPC: return 32'hffff_ffff;
            default:                    return 32'd0;   // Read-only
        endcase
    endfunction

    function automatic logic [3:0] random_after(input logic [3:0] cur, input logic [3:0] wired);
        logic [3:0] n;
        n = cur + 4'd1;
        return (n < wired) ? wired : n;
    endfunction

    function automatic tlb_entry_t entry_from_regs();
        tlb_entry_t e;
        e.vpn2 = s_reg[CP0_ENTRYHI][31:13];
        e.asid = s_reg[CP0_ENTRYHI][7:0];
        e.g = s_reg[CP0_ENTRYLO0][0] & s_reg[CP0_ENTRYLO1][0];   // Global only if both halves say so
        {e.pfn0, e.c0, e.d0, e.v0} = s_reg[CP0_ENTRYLO0][25:1];
        {e.pfn1, e.c1, e.d1, e.v1} = s_reg[CP0_ENTRYLO1][25:1];
        return e;
    endfunction

    function automatic logic slot_matches(input int i, input logic [18:0] vpn2);
        return s_filled[i] && s_tlb[i].vpn2 == vpn2 &&
               (s_tlb[i].g || s_tlb[i].asid == s_reg[CP0_ENTRYHI][7:0]);
    endfunction

    function automatic logic [35:0] expect_xlate(input logic [31:0] va, input logic wr);
        logic [24:0] half;   // {pfn, c, d, v}
        logic hit;
        hit = 1'b0;
        half = '0;
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101)
            return {3'b000, va[28:0], va[31:29] == 3'b101, 3'b000};
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (slot_matches(i, va[31:13])) begin
                hit = 1'b1;
                half = va[12] ? {s_tlb[i].pfn1, s_tlb[i].c1, s_tlb[i].d1, s_tlb[i].v1}
                              : {s_tlb[i].pfn0, s_tlb[i].c0, s_tlb[i].d0, s_tlb[i].v0};
            end
        end
        return {half[24:5], va[11:0], half[4:2] == 3'd2, !hit, hit && !half[0],
                hit && half[0] && wr && !half[1]};
    endfunction

    always @(posedge clk) begin
        logic [3:0] widx;
        logic p_hit;
        logic [3:0] p_idx;
        tlb_entry_t rd_e;
        widx = tlbwr_i ? s_reg[CP0_RANDOM][3:0] : s_reg[CP0_INDEX][3:0];
        rd_e = s_tlb[s_reg[CP0_INDEX][3:0]];
        p_hit = 1'b0;
        p_idx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (slot_matches(i, s_reg[CP0_ENTRYHI][31:13])) begin
                p_hit = 1'b1;
                p_idx = 4'(i);
            end
        end
        if (rst) begin
            for (int i = 0; i < 32; i++)
                s_reg[i] <= 32'd0;
            s_reg[CP0_RANDOM] <= `INIT_RANDOM;
            s_reg[CP0_STATUS] <= `INIT_STATUS;
            s_reg[CP0_PRID] <= `INIT_PRID;
            s_filled <= '0;
            s_tick <= 1'b0;
        end else begin
            checked <= checked + 1;
            s_tick <= ~s_tick;
            s_reg[CP0_COUNT] <= s_reg[CP0_COUNT] + 32'(s_tick);
            if (tlbwi_i || tlbwr_i) begin
                s_tlb[widx] <= entry_from_regs();
                s_filled[widx] <= 1'b1;
            end
            if (we_i) begin
                s_reg[wr_addr_i] <= (s_reg[wr_addr_i] & ~write_mask(wr_addr_i)) |
                                    (wdata_i & write_mask(wr_addr_i));
                if (wr_addr_i == CP0_WIRED)
                    s_reg[CP0_RANDOM] <= `INIT_RANDOM;
            end
            s_reg[CP0_CAUSE][15:10] <= hw_int_i;
            if (s_reg[CP0_COUNT] == s_reg[CP0_COMPARE])
                s_reg[CP0_CAUSE][30] <= 1'b1;
            if (we_i && wr_addr_i == CP0_COMPARE)
                s_reg[CP0_CAUSE][30] <= 1'b0;
            if (!we_i) begin   // A register write wins over everything below
                if (tlbr_i) begin
                    s_reg[CP0_ENTRYHI] <= {rd_e.vpn2, 5'd0, rd_e.asid};
                    s_reg[CP0_ENTRYLO0] <= {6'd0, rd_e.pfn0, rd_e.c0, rd_e.d0, rd_e.v0, rd_e.g};
                    s_reg[CP0_ENTRYLO1] <= {6'd0, rd_e.pfn1, rd_e.c1, rd_e.d1, rd_e.v1, rd_e.g};
                end
                if (tlbp_i)
                    s_reg[CP0_INDEX] <= {~p_hit, 27'd0, p_idx};
                if (tlbwr_i)
                    s_reg[CP0_RANDOM] <= {28'd0, random_after(s_reg[CP0_RANDOM][3:0],
                                                              s_reg[CP0_WIRED][3:0])};
                if (exc_i) begin
                    if (exc_badvaddr_we_i) begin
                        s_reg[CP0_BADVADDR] <= exc_badvaddr_i;
                        s_reg[CP0_ENTRYHI][31:13] <= exc_badvaddr_i[31:13];
                    end
                    s_reg[CP0_CAUSE][31] <= exc_bd_i;
                    s_reg[CP0_CAUSE][6:2] <= exc_code_i;
                    s_reg[CP0_EPC] <= exc_epc_i;
                    s_reg[CP0_STATUS][1] <= 1'b1;
                end
                if (eret_i)
                    s_reg[CP0_STATUS][1] <= 1'b0;
            end
        end
    end

    always_comb begin
        exp_rdata = s_reg[rd_addr_i];
        exp_i = expect_xlate(iaddr_i, 1'b0);
        exp_d = expect_xlate(daddr_i, dwrite_i);
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    a_rdata: assert property (@(posedge clk) disable iff (rst) rdata_o == exp_rdata)
        else report_mismatch($sformatf("reg %0d read %h, expected %h", $sampled(rd_addr_i),
                                       $sampled(rdata_o), $sampled(exp_rdata)));
    a_int_flag: assert property (@(posedge clk) disable iff (rst)
        interrupt_flag_o == (s_reg[CP0_STATUS][15:8] & {hw_int_i, s_reg[CP0_CAUSE][9:8]}))
        else report_mismatch("interrupt_flag_o differs from IM and IP");
    a_allow_int: assert property (@(posedge clk) disable iff (rst)
        allow_int_o == (s_reg[CP0_STATUS][2:0] == 3'b001 && !exc_i))
        else report_mismatch("allow_int_o wrong");
    a_epc: assert property (@(posedge clk) disable iff (rst) epc_o == s_reg[CP0_EPC])
        else report_mismatch("epc_o wrong");
    a_iport: assert property (@(posedge clk) disable iff (rst)
        imiss_o == exp_i[2] && iinvalid_o == exp_i[1] &&
        (exp_i[2] || {ipaddr_o, iuncached_o} == exp_i[35:3]))
        else report_mismatch($sformatf("instruction port for va %h", $sampled(iaddr_i)));
    a_dport: assert property (@(posedge clk) disable iff (rst)
        dmiss_o == exp_d[2] && dinvalid_o == exp_d[1] && dmodified_o == exp_d[0] &&
        (exp_d[2] || {dpaddr_o, duncached_o} == exp_d[35:3]))
        else report_mismatch($sformatf("data port for va %h", $sampled(daddr_i)));

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            rd_addr_i <= REG_LIST[rd_pos];   // Sweep reads over all registers
            rd_pos = (rd_pos + 1) % 13;
            @(posedge clk);
        end
    endtask

    task automatic read_reg(input logic [4:0] a);
        rd_addr_i <= a;
        @(posedge clk);
    endtask

    task automatic reg_write(input logic [4:0] a, input logic [31:0] d);
        we_i <= 1'b1;
        wr_addr_i <= a;
        wdata_i <= d;
        @(posedge clk);
        we_i <= 1'b0;
        rd_addr_i <= a;   // Read back in the following cycle
    endtask

    task automatic tlb_op(input int op);
        tlbwi_i <= (op == OP_WI);
        tlbwr_i <= (op == OP_WR);
        tlbr_i <= (op == OP_R);
        tlbp_i <= (op == OP_P);
        @(posedge clk);
        {tlbwi_i, tlbwr_i, tlbr_i, tlbp_i} <= 4'b0;
    endtask

    // Low bits equal the slot, so no two entries share a vpn2
    function automatic logic [18:0] make_vpn2(input logic [3:0] slot);
        logic [31:0] r;
        r = next_random();
        return {r[31] ? 3'b110 : {1'b0, r[17:16]}, r[15:4], slot};
    endfunction

    function automatic logic [31:0] pick_addr();
        logic [31:0] r;
        r = next_random();
        if (r[31:29] == 3'b000)
            return next_random();
        return {slot_vpn2[r[3:0]], r[12], r[27:16]};
    endfunction

    task automatic load_entry(input logic [18:0] vpn2, input int op);
        reg_write(CP0_ENTRYHI, {vpn2, 13'h5a});
        reg_write(CP0_ENTRYLO0, next_random());
        reg_write(CP0_ENTRYLO1, next_random());
        tlb_op(op);
    endtask

    task automatic lookup_cycles(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = next_random();
            iaddr_i <= pick_addr();
            daddr_i <= pick_addr();
            dwrite_i <= r[0];
            idle(1);
        end
    endtask

    task automatic take_exception(input exc_code_e code);
        logic [31:0] r;
        r = next_random();
        exc_i <= 1'b1;
        exc_bd_i <= r[0];
        exc_code_i <= code;
        exc_epc_i <= next_random();
        exc_badvaddr_i <= r;
        exc_badvaddr_we_i <= r[1];
        @(posedge clk);
        exc_i <= 1'b0;
        read_reg(CP0_EPC);
        read_reg(CP0_BADVADDR);
        read_reg(CP0_CAUSE);
        read_reg(CP0_ENTRYHI);
        eret_i <= 1'b1;
        @(posedge clk);
        eret_i <= 1'b0;
        read_reg(CP0_STATUS);
    endtask

    initial begin
        logic [3:0] pred;
        logic [31:0] r;
        rst = 1'b1;
        {rd_addr_i, wr_addr_i, we_i, wdata_i} = '0;
        {tlbwi_i, tlbwr_i, tlbr_i, tlbp_i} = '0;
        {exc_i, exc_bd_i, exc_epc_i, exc_badvaddr_i, exc_badvaddr_we_i, eret_i} = '0;
        exc_code_i = EXC_INT;
        hw_int_i = '0;
        {iaddr_i, daddr_i, dwrite_i} = '0;
        foreach (slot_vpn2[i])
            slot_vpn2[i] = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        idle(14);   // Reset values of every register

        repeat (3)
            foreach (REG_LIST[k])
                reg_write(REG_LIST[k], next_random());
        idle(13);

        // Timer and interrupt lines
        reg_write(CP0_COUNT, 32'd100);
        reg_write(CP0_COMPARE, 32'd140);
        rd_addr_i <= CP0_CAUSE;
        do
            @(negedge clk);
        while (!rdata_o[30]);
        @(posedge clk);
        idle(4);
        reg_write(CP0_COMPARE, 32'hffff_0000);
        reg_write(CP0_STATUS, 32'h0000_ff01);
        repeat (24) begin
            r = next_random();
            hw_int_i <= r[5:0];
            if (r[8])
                reg_write(CP0_CAUSE, r);
            else
                idle(1);
        end

        for (int k = 0; k < 20; k++) begin
            slot_vpn2[k % 16] = make_vpn2(4'(k % 16));
            reg_write(CP0_INDEX, 32'(k % 16));
            load_entry(slot_vpn2[k % 16], OP_WI);
        end
        for (int round = 0; round < 4; round++) begin
            // Odd rounds switch ASID so only global entries still hit
            reg_write(CP0_ENTRYHI, {make_vpn2(4'd0), 5'd0, (round % 2) ? 8'h3c : 8'h5a});
            lookup_cycles(50);
        end

        for (int s = 0; s < `TLB_ENTRIES; s++) begin
            reg_write(CP0_ENTRYHI, {slot_vpn2[s], 13'h5a});
            tlb_op(OP_P);
            tlb_op(OP_R);
            read_reg(CP0_ENTRYHI);
            read_reg(CP0_ENTRYLO0);
            read_reg(CP0_ENTRYLO1);
            reg_write(CP0_ENTRYHI, {3'b111, 12'h0, 4'(s), 13'h5a});   // Never written
            tlb_op(OP_P);
            read_reg(CP0_INDEX);
        end

        reg_write(CP0_WIRED, 32'd5);
        pred = 4'(`TLB_ENTRIES - 1);
        repeat (20) begin
            slot_vpn2[pred] = make_vpn2(pred);
            load_entry(slot_vpn2[pred], OP_WR);
            read_reg(CP0_RANDOM);
            reg_write(CP0_INDEX, {28'd0, pred});
            tlb_op(OP_R);
            read_reg(CP0_ENTRYHI);
            iaddr_i <= {slot_vpn2[pred], 13'd0};
            read_reg(CP0_ENTRYLO0);
            pred = random_after(pred, 4'd5);
        end

        reg_write(CP0_STATUS, 32'h0000_ff01);
        take_exception(EXC_TLBL);
        take_exception(EXC_MOD);
        take_exception(EXC_TLBS);
        take_exception(EXC_SYS);
        repeat (20) begin
            r = next_random();
            iaddr_i <= {3'b100, r[28:0]};
            daddr_i <= {3'b101, 29'(next_random())};
            dwrite_i <= r[31];
            idle(1);
        end
        idle(4);

        $display("Summary: %0d cycles checked, %0d mismatches", checked, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
cp0_pkg.sv
tlb_pkg.sv
addr_translate.sv
tlb_array.sv
cp0_regs.sv
cp0_mmu_top.sv
tb_cp0_mmu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CP0/MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_cp0_mmu -o sim_cp0_mmu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cp0_mmu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0
